// File: build.f
verilog/spike_delay_pkg.sv
verilog/tick_timer.sv
verilog/spike_counter.sv
verilog/delay_fill_fsm.sv
verilog/spike_ram.sv
verilog/count_delay_line.sv
verilog/spike_delay_top.sv
testbench/tb_spike_delay.sv

// File: run.sh
#!/bin/sh
# compile and run the spike delay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_spike_delay \
    --Mdir obj_dir -o tb_spike_delay

# keep the output even if the simulation stops on an assertion
sim_out=$(./obj_dir/tb_spike_delay) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL CHECKS PASSED"
then
    exit 0
fi
exit 1

// File: testbench/tb_spike_delay.sv
`timescale 1ns/100ps
`default_nettype none

module tb_spike_delay
    import spike_delay_pkg::*;
();

    // room for every neuron tick between two resets
    localparam int HIST_DEPTH = 4096;

    logic         ep50trig;
    logic         reset_global;
    logic         i_spike;
    logic         i_rate_load;
    half_cnt_t    i_half_cnt;
    logic         o_neuron_tick;
    logic         o_sim_tick;
    logic         o_spike_delayed;
    logic         o_spike_delayed_twice;
    spike_count_t o_count_direct;
    spike_count_t o_count_late;
    spike_count_t o_count_delayed;
    spike_count_t o_count_delayed_twice;

    int mismatches = 0;
    int timeouts = 0;

    // spike sampled on each neuron tick since reset
    logic         hist [HIST_DEPTH];
    int           n_ticks;
    // edges since the last tick, strobe or reset
    int           tick_gap;
    half_cnt_t    half_ref;
    // expected output values
    logic         exp_tick;
    logic         exp_sim;
    logic         exp_d1;
    logic         exp_d2;
    spike_count_t exp_direct;
    spike_count_t exp_late;
    spike_count_t exp_delayed;
    spike_count_t exp_twice;
    // direct counts waiting to come out late
    spike_count_t late_q [$];
    logic [31:0]  lcg_state;

    spike_delay_top spike_delay_top_inst (
        .ep50trig              (ep50trig),
        .reset_global          (reset_global),
        .i_spike               (i_spike),
        .i_rate_load           (i_rate_load),
        .i_half_cnt            (i_half_cnt),
        .o_neuron_tick         (o_neuron_tick),
        .o_sim_tick            (o_sim_tick),
        .o_spike_delayed       (o_spike_delayed),
        .o_spike_delayed_twice (o_spike_delayed_twice),
        .o_count_direct        (o_count_direct),
        .o_count_late          (o_count_late),
        .o_count_delayed       (o_count_delayed),
        .o_count_delayed_twice (o_count_delayed_twice)
    );

    // 4 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever #2 ep50trig = ~ep50trig;
    end

    //////////////////////////////////////////////////
    // reference
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // spike sampled lag ticks before tick idx, 0 before the stream starts
    function automatic logic lagged_spike(input int idx, input int lag);
        if (idx < lag)
        begin
            return 1'b0;
        end
        return hist[idx - lag];
    endfunction

    // spikes of the step that ends on tick last
    function automatic spike_count_t step_count(input int last, input int lag);
        spike_count_t total;
        total = '0;
        for (int j = last - SIM_DIV + 1; j <= last; j++)
        begin
            total = total + spike_count_t'(lagged_spike(j, lag));
        end
        return total;
    endfunction

    task automatic clear_model();
        n_ticks     = 0;
        tick_gap    = 0;
        half_ref    = DEFAULT_HALF_CNT;
        exp_tick    = 1'b0;
        exp_sim     = 1'b0;
        exp_d1      = 1'b0;
        exp_d2      = 1'b0;
        exp_direct  = '0;
        exp_late    = '0;
        exp_delayed = '0;
        exp_twice   = '0;
        late_q.delete();
    endtask

    task automatic update_model();
        // the cycle just taken carried a neuron tick
        if (exp_tick)
        begin
            hist[n_ticks] = i_spike;
            exp_d1 = lagged_spike(n_ticks, DELAY_DEPTH);
            exp_d2 = lagged_spike(n_ticks, 2 * DELAY_DEPTH);
            if (exp_sim)
            begin
                // delay line takes the count still on the output
                late_q.push_back(exp_direct);
                if (late_q.size() == COUNT_DELAY_STAGES)
                begin
                    exp_late = late_q.pop_front();
                end
                exp_direct  = step_count(n_ticks, 0);
                // counters see each delayed output one tick after it moves
                exp_delayed = step_count(n_ticks, DELAY_DEPTH + 1);
                exp_twice   = step_count(n_ticks, 2 * DELAY_DEPTH + 1);
            end
            n_ticks++;
        end
        // strobe restarts the period, no tick on that edge
        if (i_rate_load)
        begin
            half_ref = i_half_cnt;
            tick_gap = 0;
            exp_tick = 1'b0;
        end
        else
        begin
            tick_gap++;
            exp_tick = (tick_gap == int'(half_ref) + 1);
            if (exp_tick)
            begin
                tick_gap = 0;
            end
        end
        // 16th, 32nd ... tick since reset
        exp_sim = exp_tick && ((n_ticks % SIM_DIV) == SIM_DIV - 1);
    endtask

    task automatic check_value(input string name, input spike_count_t got,
                               input spike_count_t exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // comparison, 1 ns after each rising edge
    //////////////////////////////////////////////////

    initial
    begin
        forever
        begin
            @(posedge ep50trig);
            #1;
            if (reset_global)
            begin
                clear_model();
            end
            else
            begin
                update_model();
            end
            check_value("o_neuron_tick", spike_count_t'(o_neuron_tick),
                        spike_count_t'(exp_tick));
            check_value("o_sim_tick", spike_count_t'(o_sim_tick), spike_count_t'(exp_sim));
            check_value("o_spike_delayed", spike_count_t'(o_spike_delayed),
                        spike_count_t'(exp_d1));
            check_value("o_spike_delayed_twice", spike_count_t'(o_spike_delayed_twice),
                        spike_count_t'(exp_d2));
            check_value("o_count_direct", o_count_direct, exp_direct);
            check_value("o_count_late", o_count_late, exp_late);
            check_value("o_count_delayed", o_count_delayed, exp_delayed);
            check_value("o_count_delayed_twice", o_count_delayed_twice, exp_twice);
        end
    end

    // random spike level, new value on every falling edge
    initial
    begin
        i_spike   = 1'b0;
        lcg_state = 32'd94257;
        forever
        begin
            @(negedge ep50trig);
            lcg_state = lcg_next(lcg_state);
            i_spike   = lcg_state[16];
        end
    end

    //////////////////////////////////////////////////
    // waits
    //////////////////////////////////////////////////

    task automatic wait_ticks(input int count, input int limit);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < limit)
        begin
            @(negedge ep50trig);
            cycles++;
            if (o_neuron_tick)
            begin
                seen++;
            end
        end
        if (seen < count)
        begin
            timeouts++;
            $display("Timeout at %0t: only %0d of %0d neuron ticks came in %0d cycles",
                     $time, seen, count, limit);
        end
    endtask

    // falling edges until the next neuron tick shows up
    task automatic measure_gap(input int expected, input int limit, input string what);
        int   gap;
        logic seen;
        gap  = 0;
        seen = 1'b0;
        while (!seen && gap < limit)
        begin
            @(negedge ep50trig);
            gap++;
            // rate strobe lasts one cycle
            i_rate_load = 1'b0;
            seen = o_neuron_tick;
        end
        if (!seen)
        begin
            timeouts++;
            $display("Timeout at %0t: no neuron tick within %0d cycles after %s",
                     $time, limit, what);
        end
        else if (gap != expected)
        begin
            mismatches++;
            $display("Mismatch at %0t: o_neuron_tick gap after %s got %0d expected %0d",
                     $time, what, gap, expected);
        end
    endtask

    // strobe is taken on the next edge, tick value+1 edges after that
    task automatic load_rate(input half_cnt_t value, input int limit);
        i_half_cnt  = value;
        i_rate_load = 1'b1;
        measure_gap(int'(value) + 2, limit, "rate load");
    endtask

    //////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////

    initial
    begin
        reset_global = 1'b1;
        i_rate_load  = 1'b0;
        i_half_cnt   = '0;
        repeat (8) @(negedge ep50trig);
        reset_global = 1'b0;
        measure_gap(int'(DEFAULT_HALF_CNT) + 1, 20, "reset");

        // default rate, long enough to fill both memories and the delay line
        wait_ticks(200, 2000);

        // tick on every cycle
        load_rate(16'd0, 20);
        wait_ticks(150, 400);

        // ticks 7 cycles apart
        load_rate(16'd6, 40);
        wait_ticks(40, 400);

        // reset in the middle of a run
        reset_global = 1'b1;
        repeat (8) @(negedge ep50trig);
        reset_global = 1'b0;
        measure_gap(int'(DEFAULT_HALF_CNT) + 1, 20, "second reset");
        // memories refill from zero
        wait_ticks(110, 1000);

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/spike_delay_top.sv
`timescale 1ns/100ps
`default_nettype none

module spike_delay_top
    import spike_delay_pkg::*;
(
    input  wire            ep50trig,
    input  wire            reset_global,
    // motor neuron spike level
    input  wire            i_spike,
    // rate strobe and period value
    input  wire            i_rate_load,
    input  wire half_cnt_t i_half_cnt,
    output logic           o_neuron_tick,
    output logic           o_sim_tick,
    output logic           o_spike_delayed,
    output logic           o_spike_delayed_twice,
    output spike_count_t   o_count_direct,
    output spike_count_t   o_count_late,
    output spike_count_t   o_count_delayed,
    output spike_count_t   o_count_delayed_twice
);

    // shared memory index and fill flag
    delay_addr_t addr;
    logic        filled;

    //////////////////////////////////////////////////
    // tick enables
    //////////////////////////////////////////////////

    tick_timer tick_timer_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_rate_load   (i_rate_load),
        .i_half_cnt    (i_half_cnt),
        .o_neuron_tick (o_neuron_tick),
        .o_sim_tick    (o_sim_tick)
    );

    //////////////////////////////////////////////////
    // spike delay chain
    //////////////////////////////////////////////////

    delay_fill_fsm delay_fill_fsm_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (o_neuron_tick),
        .o_addr        (addr),
        .o_filled      (filled)
    );

    // first memory, raw stream in
    spike_ram spike_ram_1_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (o_neuron_tick),
        .i_addr        (addr),
        .i_filled      (filled),
        .i_spike       (i_spike),
        .o_spike       (o_spike_delayed)
    );

    // second memory fed by the first
    spike_ram #(
        .READ_LEAD (CHAIN_READ_LEAD)
    ) spike_ram_2_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (o_neuron_tick),
        .i_addr        (addr),
        .i_filled      (filled),
        .i_spike       (o_spike_delayed),
        .o_spike       (o_spike_delayed_twice)
    );

    //////////////////////////////////////////////////
    // per-step counts
    //////////////////////////////////////////////////

    spike_counter count_direct_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (o_neuron_tick),
        .i_sim_tick    (o_sim_tick),
        .i_spike       (i_spike),
        .o_count       (o_count_direct)
    );

    spike_counter count_delayed_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (o_neuron_tick),
        .i_sim_tick    (o_sim_tick),
        .i_spike       (o_spike_delayed),
        .o_count       (o_count_delayed)
    );

    spike_counter count_delayed_twice_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_neuron_tick (o_neuron_tick),
        .i_sim_tick    (o_sim_tick),
        .i_spike       (o_spike_delayed_twice),
        .o_count       (o_count_delayed_twice)
    );

    // direct count held back COUNT_DELAY_STAGES steps
    count_delay_line count_delay_line_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_tick   (o_sim_tick),
        .i_count      (o_count_direct),
        .o_count      (o_count_late)
    );

endmodule

`default_nettype wire

// File: verilog/count_delay_line.sv
`timescale 1ns/100ps
`default_nettype none

module count_delay_line
    import spike_delay_pkg::*;
(
    input  wire               ep50trig,
    input  wire               reset_global,
    input  wire               i_sim_tick,
    input  wire spike_count_t i_count,
    output spike_count_t      o_count
);

    // stage 0 is the newest count
    spike_count_t stage_q [COUNT_DELAY_STAGES];

    //////////////////////////////////////////////////
    // shift chain
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            // counts read as zero until the chain has filled
            for (int i = 0; i < COUNT_DELAY_STAGES; i++)
            begin
                stage_q[i] <= '0;
            end
        end
        else if (i_sim_tick)
        begin
            // takes the direct count as it stands this cycle
            // which is the one published on the previous step
            stage_q[0] <= i_count;
            for (int i = 1; i < COUNT_DELAY_STAGES; i++)
            begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // oldest stage
    assign o_count = stage_q[COUNT_DELAY_STAGES-1];

endmodule

`default_nettype wire

// File: verilog/spike_ram.sv
`timescale 1ns/100ps
`default_nettype none

module spike_ram
    import spike_delay_pkg::*;
#(
    // read slot offset from the write slot
    parameter int READ_LEAD = 0
)
(
    input  wire              ep50trig,
    input  wire              reset_global,
    input  wire              i_neuron_tick,
    input  wire delay_addr_t i_addr,
    input  wire              i_filled,
    input  wire              i_spike,
    output logic             o_spike
);

    // one bit per neuron tick of history
    logic        mem [DELAY_DEPTH];
    // read slot, wraps with the index width
    delay_addr_t rd_addr;

    // with a lead of one, the oldest slot is read a tick early,
    // which makes up for the upstream output register
    assign rd_addr = i_addr + delay_addr_t'(READ_LEAD);

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (i_neuron_tick)
        begin
            mem[i_addr] <= i_spike;
        end
    end

    // read port, sees the old contents on the same tick
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_spike <= 1'b0;
        end
        else if (i_neuron_tick)
        begin
            // slots hold garbage until the first wrap
            o_spike <= i_filled & mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/delay_fill_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module delay_fill_fsm
    import spike_delay_pkg::*;
(
    input  wire         ep50trig,
    input  wire         reset_global,
    input  wire         i_neuron_tick,
    output delay_addr_t o_addr,
    output logic        o_filled
);

    fill_state_t state_q;
    fill_state_t state_d;
    // shared slot index for both memories
    delay_addr_t addr_q;
    // index sits on the last slot
    logic        addr_last;

    assign addr_last = (addr_q == delay_addr_t'(DELAY_DEPTH - 1));

    //////////////////////////////////////////////////
    // fill state
    //////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            FILLING:
            begin
                // first wrap, every slot now holds a real sample
                if (i_neuron_tick && addr_last)
                begin
                    state_d = RUNNING;
                end
            end
            RUNNING:
            begin
                state_d = RUNNING;
            end
            default:
            begin
                state_d = FILLING;
            end
        endcase
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            state_q <= FILLING;
            addr_q  <= '0;
        end
        else
        begin
            state_q <= state_d;
            // index steps once per neuron tick, modulo depth
            if (i_neuron_tick)
            begin
                addr_q <= addr_last ? '0 : addr_q + 1'b1;
            end
        end
    end

    assign o_addr   = addr_q;
    assign o_filled = (state_q == RUNNING);

    // only a reset takes the memories back to filling
    property p_running_sticks;
        @(posedge ep50trig) disable iff (reset_global)
        (state_q == RUNNING) |=> (state_q == RUNNING);
    endproperty
    a_running_sticks: assert property (p_running_sticks);

endmodule

`default_nettype wire

// File: verilog/spike_counter.sv
`timescale 1ns/100ps
`default_nettype none

module spike_counter
    import spike_delay_pkg::*;
(
    input  wire          ep50trig,
    input  wire          reset_global,
    input  wire          i_neuron_tick,
    input  wire          i_sim_tick,
    input  wire          i_spike,
    output spike_count_t o_count
);

    // running total within the current step
    spike_count_t total_q;
    // spike level widened for the adder
    spike_count_t spike_inc;

    assign spike_inc = spike_count_t'(i_spike);

    //////////////////////////////////////////////////
    // window count
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            total_q <= '0;
            o_count <= '0;
        end
        else if (i_sim_tick)
        begin
            // last neuron tick of the step counts too
            // sim tick only ever comes with a neuron tick
            o_count <= total_q + spike_inc;
            total_q <= '0;
        end
        else if (i_neuron_tick)
        begin
            total_q <= total_q + spike_inc;
        end
    end

    // a step holds SIM_DIV neuron ticks, so no window can count more
    property p_count_bounded;
        @(posedge ep50trig) disable iff (reset_global)
        o_count <= spike_count_t'(SIM_DIV);
    endproperty
    a_count_bounded: assert property (p_count_bounded);

endmodule

`default_nettype wire

// File: verilog/tick_timer.sv
`timescale 1ns/100ps
`default_nettype none

module tick_timer
    import spike_delay_pkg::*;
(
    input  wire            ep50trig,
    input  wire            reset_global,
    input  wire            i_rate_load,
    input  wire half_cnt_t i_half_cnt,
    output logic           o_neuron_tick,
    output logic           o_sim_tick
);

    // period register, loaded by the rate strobe
    half_cnt_t half_cnt_q;
    // down-counter to next neuron tick
    half_cnt_t tick_cnt_q;
    // neuron ticks seen, modulo SIM_DIV
    sim_div_t  sim_div_q;
    // neuron tick goes out on the next edge
    logic      tick_due;

    // a load restarts the period, so no tick that cycle
    assign tick_due = (tick_cnt_q == '0) && !i_rate_load;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            half_cnt_q <= DEFAULT_HALF_CNT;
        end
        else if (i_rate_load)
        begin
            half_cnt_q <= i_half_cnt;
        end
    end

    //////////////////////////////////////////////////
    // neuron tick
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            tick_cnt_q    <= DEFAULT_HALF_CNT;
            o_neuron_tick <= 1'b0;
        end
        else if (i_rate_load)
        begin
            // new value counts from the strobe
            tick_cnt_q    <= i_half_cnt;
            o_neuron_tick <= 1'b0;
        end
        else if (tick_cnt_q == '0)
        begin
            tick_cnt_q    <= half_cnt_q;
            o_neuron_tick <= 1'b1;
        end
        else
        begin
            tick_cnt_q    <= tick_cnt_q - 1'b1;
            o_neuron_tick <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // simulation tick
    //////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            sim_div_q  <= '0;
            o_sim_tick <= 1'b0;
        end
        else if (tick_due)
        begin
            // 16th, 32nd ... neuron tick after reset
            sim_div_q  <= sim_div_q + 1'b1;
            o_sim_tick <= (sim_div_q == sim_div_t'(SIM_DIV - 1));
        end
        else
        begin
            o_sim_tick <= 1'b0;
        end
    end

    // step boundary always lines up with a neuron tick
    property p_sim_within_neuron;
        @(posedge ep50trig) disable iff (reset_global)
        o_sim_tick |-> o_neuron_tick;
    endproperty
    a_sim_within_neuron: assert property (p_sim_within_neuron);

endmodule

`default_nettype wire

// File: verilog/spike_delay_pkg.sv
`default_nettype none

package spike_delay_pkg;

    //////////////////////////////////////////////////
    // widths that carry a meaning
    //////////////////////////////////////////////////

    // spikes counted in one simulation step
    typedef logic [31:0] spike_count_t;

    // neuron tick period setting, ticks come every value+1 cycles
    typedef logic [15:0] half_cnt_t;

    // slot index into the circular spike memories
    typedef logic [4:0] delay_addr_t;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // memory entries = delay in neuron ticks
    localparam int DELAY_DEPTH = 32;

    // neuron ticks per simulation tick
    localparam int SIM_DIV = 16;
    localparam int SIM_DIV_W = $clog2(SIM_DIV);
    typedef logic [SIM_DIV_W-1:0] sim_div_t;

    // simulation steps of delay on the direct count
    localparam int COUNT_DELAY_STAGES = 8;

    // second memory reads one slot ahead
    // so the chain lands on exactly twice the delay
    localparam int CHAIN_READ_LEAD = 1;

    // period setting after reset
    localparam half_cnt_t DEFAULT_HALF_CNT = 16'd3;

    // memory fill tracking
    typedef enum logic {
        FILLING,
        RUNNING
    } fill_state_t;

endpackage

`default_nettype wire
